/* hdl/radio_pkg.sv */
// widths, iq sample and settings types, settings word union, sine table
package radio_pkg;

   // --------------------
   // widths
   // --------------------
   localparam int unsigned SAMPLE_W        = 16;
   localparam int unsigned SET_ADDR_W      = 8;
   localparam int unsigned SET_DATA_W      = 32;
   localparam int unsigned PHASE_W         = 16;
   localparam int unsigned NUM_TX_CHANNELS = 2;

   localparam logic signed [SAMPLE_W-1:0] SAMPLE_MAX = 16'sh7fff;
   localparam logic signed [SAMPLE_W-1:0] SAMPLE_MIN = 16'sh8000;

   // --------------------
   // sample and settings types
   // --------------------
   typedef struct packed {
      logic signed [SAMPLE_W-1:0] i;   // upper half of the word
      logic signed [SAMPLE_W-1:0] q;
   } iq_sample_t;

   typedef struct packed {
      logic [SET_DATA_W-4:0] reserved;
      logic                  negate_q;   // bit 2
      logic                  swap_iq;    // bit 1
      logic                  use_tone;   // bit 0, tone instead of host
   } fe_ctrl_t;

   typedef struct packed {
      logic signed [SAMPLE_W-1:0] i_offset;
      logic signed [SAMPLE_W-1:0] q_offset;
   } dc_offset_t;

   // one data word, meaning picked by the register address
   typedef union packed {
      fe_ctrl_t   ctrl;
      dc_offset_t offset;
   } settings_word_u;

   typedef struct packed {
      fe_ctrl_t   ctrl;
      dc_offset_t offset;
   } fe_cfg_t;

   // --------------------
   // tone table
   // --------------------
   localparam int unsigned SINE_DEPTH  = 16;
   localparam int unsigned SINE_ADDR_W = $clog2(SINE_DEPTH);

   // round(32767 * sin(k * 22.5 deg))
   localparam logic signed [SAMPLE_W-1:0] SINE_TABLE [SINE_DEPTH] = '{
       16'sd0,      16'sd12539,  16'sd23170,  16'sd30273,
       16'sd32767,  16'sd30273,  16'sd23170,  16'sd12539,
       16'sd0,     -16'sd12539, -16'sd23170, -16'sd30273,
      -16'sd32767, -16'sd30273, -16'sd23170, -16'sd12539
   };

endpackage

/* hdl/settings_regs.sv */
// settings bus decoder holding per-channel front-end config and tone increment
`timescale 1ns/100ps

module settings_regs #(
   parameter logic [radio_pkg::SET_ADDR_W-1:0] SR_BASE = 8'd160
) (
   input  logic                              radio_clk,
   input  logic                              i_arst_n,
   // settings bus
   input  logic                              i_set_stb,
   input  logic [radio_pkg::SET_ADDR_W-1:0]  i_set_addr,
   input  radio_pkg::settings_word_u         i_set_data,
   // decoded registers
   output radio_pkg::fe_cfg_t                o_fe_cfg [radio_pkg::NUM_TX_CHANNELS],
   output logic [radio_pkg::PHASE_W-1:0]     o_phase_inc
);
   import radio_pkg::*;

   // two registers per channel, tone increment right after them
   localparam logic [SET_ADDR_W-1:0] TONE_ADDR = SET_ADDR_W'(2 * NUM_TX_CHANNELS);

   logic [SET_ADDR_W-1:0] rel_addr;

   // addresses below the base wrap high and miss every register
   assign rel_addr = i_set_addr - SR_BASE;

   // --------------------
   // per-channel front-end registers
   // --------------------
   for (genvar ch = 0; ch < NUM_TX_CHANNELS; ch++) begin : g_chan
      localparam logic [SET_ADDR_W-1:0] CTRL_ADDR = SET_ADDR_W'(2 * ch);
      localparam logic [SET_ADDR_W-1:0] OFFS_ADDR = SET_ADDR_W'(2 * ch + 1);

      always_ff @(posedge radio_clk or negedge i_arst_n) begin
         if (!i_arst_n) begin
            o_fe_cfg[ch] <= '0;   // host source, no swap, no offset
         end else if (i_set_stb) begin
            if (rel_addr == CTRL_ADDR) begin
               o_fe_cfg[ch].ctrl <= i_set_data.ctrl;
            end
            if (rel_addr == OFFS_ADDR) begin
               o_fe_cfg[ch].offset <= i_set_data.offset;
            end
         end
      end
   end

   // --------------------
   // tone increment
   // --------------------
   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_phase_inc <= '0;
      end else if (i_set_stb && (rel_addr == TONE_ADDR)) begin
         o_phase_inc <= i_set_data[PHASE_W-1:0];   // upper data bits dropped
      end
   end

endmodule

/* hdl/tone_source.sv */
// phase accumulator with sine table lookup, one registered I/Q tone sample per cycle
`timescale 1ns/100ps

module tone_source (
   input  logic                          radio_clk,
   input  logic                          i_arst_n,
   input  logic [radio_pkg::PHASE_W-1:0] i_phase_inc,
   output radio_pkg::iq_sample_t         o_tone
);
   import radio_pkg::*;

   // cosine is the sine a quarter turn ahead
   localparam logic [SINE_ADDR_W-1:0] QUARTER = SINE_ADDR_W'(SINE_DEPTH / 4);

   logic [PHASE_W-1:0]     phase;
   logic [SINE_ADDR_W-1:0] sin_idx;
   logic [SINE_ADDR_W-1:0] cos_idx;

   // --------------------
   // phase accumulator
   // --------------------
   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         phase <= '0;
      end else begin
         phase <= phase + i_phase_inc;   // wraps mod 2**PHASE_W
      end
   end

   // table address from the top phase bits
   assign sin_idx = phase[PHASE_W-1 -: SINE_ADDR_W];
   assign cos_idx = sin_idx + QUARTER;   // wraps mod table depth

   // --------------------
   // table lookup
   // --------------------
   // one cycle behind the phase register
   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_tone <= '0;
      end else begin
         o_tone.i <= SINE_TABLE[cos_idx];
         o_tone.q <= SINE_TABLE[sin_idx];
      end
   end

endmodule

/* hdl/tx_frontend.sv */
// transmit front end: source select, IQ swap, Q negate, saturating DC offset
`timescale 1ns/100ps

module tx_frontend (
   input  logic                  radio_clk,
   input  logic                  i_arst_n,
   input  radio_pkg::fe_cfg_t    i_cfg,
   input  radio_pkg::iq_sample_t i_host,
   input  radio_pkg::iq_sample_t i_tone,
   input  logic                  i_stb,
   output radio_pkg::iq_sample_t o_sample,
   output logic                  o_stb
);
   import radio_pkg::*;

   iq_sample_t sel;       // chosen source
   iq_sample_t swapped;
   iq_sample_t negated;
   iq_sample_t nxt;       // offset applied

   // negation of the most negative value clips to full scale
   function automatic logic signed [SAMPLE_W-1:0] neg_sat(
      input logic signed [SAMPLE_W-1:0] x
   );
      return (x == SAMPLE_MIN) ? SAMPLE_MAX : -x;
   endfunction

   function automatic logic signed [SAMPLE_W-1:0] add_sat(
      input logic signed [SAMPLE_W-1:0] a,
      input logic signed [SAMPLE_W-1:0] b
   );
      logic signed [SAMPLE_W:0] sum;   // one guard bit
      sum = a + b;
      if (sum[SAMPLE_W] != sum[SAMPLE_W-1]) begin
         return sum[SAMPLE_W] ? SAMPLE_MIN : SAMPLE_MAX;   // overflow, clip by sign
      end
      return sum[SAMPLE_W-1:0];
   endfunction

   // --------------------
   // datapath
   // --------------------
   always_comb begin
      sel = i_cfg.ctrl.use_tone ? i_tone : i_host;

      swapped = sel;
      if (i_cfg.ctrl.swap_iq) begin
         swapped.i = sel.q;
         swapped.q = sel.i;
      end

      negated = swapped;
      if (i_cfg.ctrl.negate_q) begin
         negated.q = neg_sat(swapped.q);
      end

      nxt.i = add_sat(negated.i, i_cfg.offset.i_offset);
      nxt.q = add_sat(negated.q, i_cfg.offset.q_offset);
   end

   // --------------------
   // output register
   // --------------------
   always_ff @(posedge radio_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_sample <= '0;
         o_stb    <= 1'b0;
      end else begin
         o_sample <= nxt;     // loaded every cycle, strobe marks the valid ones
         o_stb    <= i_stb;
      end
   end

endmodule

/* hdl/radio_core.sv */
// top level: settings registers, shared tone source and one front end per tx channel
`timescale 1ns/100ps

module radio_core #(
   parameter logic [radio_pkg::SET_ADDR_W-1:0] SR_BASE = 8'd160
) (
   input  logic                                    radio_clk,
   input  logic                                    i_arst_n,
   // settings bus
   input  logic                                    i_set_stb,
   input  logic [radio_pkg::SET_ADDR_W-1:0]        i_set_addr,
   input  radio_pkg::settings_word_u               i_set_data,
   // host samples in
   input  radio_pkg::iq_sample_t                   i_tx_host [radio_pkg::NUM_TX_CHANNELS],
   input  logic [radio_pkg::NUM_TX_CHANNELS-1:0]   i_tx_stb,
   // to the DACs, tx0 and tx1
   output radio_pkg::iq_sample_t                   o_tx [radio_pkg::NUM_TX_CHANNELS],
   output logic [radio_pkg::NUM_TX_CHANNELS-1:0]   o_tx_stb
);
   import radio_pkg::*;

   fe_cfg_t            fe_cfg [NUM_TX_CHANNELS];
   logic [PHASE_W-1:0] phase_inc;
   iq_sample_t         tone;   // shared by all channels

   // --------------------
   // control
   // --------------------
   settings_regs #(
      .SR_BASE (SR_BASE)
   ) u_settings (
      .radio_clk   (radio_clk),
      .i_arst_n    (i_arst_n),
      .i_set_stb   (i_set_stb),
      .i_set_addr  (i_set_addr),
      .i_set_data  (i_set_data),
      .o_fe_cfg    (fe_cfg),
      .o_phase_inc (phase_inc)
   );

   tone_source u_tone (
      .radio_clk   (radio_clk),
      .i_arst_n    (i_arst_n),
      .i_phase_inc (phase_inc),
      .o_tone      (tone)
   );

   // --------------------
   // front ends
   // --------------------
   for (genvar ch = 0; ch < NUM_TX_CHANNELS; ch++) begin : g_fe
      tx_frontend u_fe (
         .radio_clk (radio_clk),
         .i_arst_n  (i_arst_n),
         .i_cfg     (fe_cfg[ch]),
         .i_host    (i_tx_host[ch]),
         .i_tone    (tone),
         .i_stb     (i_tx_stb[ch]),
         .o_sample  (o_tx[ch]),
         .o_stb     (o_tx_stb[ch])
      );
   end

endmodule

/* tests/radio_core_properties.sv */
// concurrent assertions on tx strobe latency and reset values, bound into radio_core
`timescale 1ns/100ps

module radio_core_properties (
   input  logic                                  radio_clk,
   input  logic                                  i_arst_n,
   input  logic [radio_pkg::NUM_TX_CHANNELS-1:0] i_tx_stb,
   input  radio_pkg::iq_sample_t                 i_out_tx [radio_pkg::NUM_TX_CHANNELS],
   input  logic [radio_pkg::NUM_TX_CHANNELS-1:0] i_out_tx_stb
);
   import radio_pkg::*;

   int unsigned fails = 0;   // read by the testbench

   // output strobe is the input strobe one edge later
   a_stb_latency: assert property (@(posedge radio_clk) disable iff (!i_arst_n)
      $past(i_arst_n) |-> (i_out_tx_stb == $past(i_tx_stb)))
   else begin
      fails++;
      $error("o_tx_stb does not follow i_tx_stb of the previous cycle");
   end

   for (genvar ch = 0; ch < NUM_TX_CHANNELS; ch++) begin : g_rst
      a_reset_zero: assert property (@(negedge radio_clk)
         !i_arst_n |-> (i_out_tx[ch] == '0 && !i_out_tx_stb[ch]))
      else begin
         fails++;
         $error("o_tx[%0d] or its strobe is not zero during reset", ch);
      end
   end

endmodule

bind radio_core radio_core_properties u_props (
   .radio_clk    (radio_clk),
   .i_arst_n     (i_arst_n),
   .i_tx_stb     (i_tx_stb),
   .i_out_tx     (o_tx),
   .i_out_tx_stb (o_tx_stb)
);

/* tests/radio_core_checker.sv */
// reference model of the tx path, checks every output strobe and valid sample
`timescale 1ns/100ps

module radio_core_checker #(
   parameter logic [radio_pkg::SET_ADDR_W-1:0] SR_BASE = 8'd160
) (
   input  logic                                  radio_clk,
   input  logic                                  i_arst_n,
   input  logic                                  i_set_stb,
   input  logic [radio_pkg::SET_ADDR_W-1:0]      i_set_addr,
   input  logic [radio_pkg::SET_DATA_W-1:0]      i_set_data,
   input  radio_pkg::iq_sample_t                 i_tx_host [radio_pkg::NUM_TX_CHANNELS],
   input  logic [radio_pkg::NUM_TX_CHANNELS-1:0] i_tx_stb,
   input  radio_pkg::iq_sample_t                 i_dut_tx [radio_pkg::NUM_TX_CHANNELS],
   input  logic [radio_pkg::NUM_TX_CHANNELS-1:0] i_dut_tx_stb,
   output int unsigned                           o_errors,
   output int unsigned                           o_checks
);
   import radio_pkg::*;

   localparam int TONE_REL = 2 * NUM_TX_CHANNELS;   // increment register offset

   // state as the DUT holds it after the last rising edge
   logic [2:0] m_ctrl [NUM_TX_CHANNELS];   // negate, swap, use_tone
   int m_off_i [NUM_TX_CHANNELS];
   int m_off_q [NUM_TX_CHANNELS];
   int m_inc;
   int m_phase;
   int m_tone_i;
   int m_tone_q;
   // prediction for the next edge
   int exp_i [NUM_TX_CHANNELS];
   int exp_q [NUM_TX_CHANNELS];
   logic [NUM_TX_CHANNELS-1:0] exp_stb;

   function automatic int clip(input int v);
      return (v > 32767) ? 32767 : ((v < -32768) ? -32768 : v);
   endfunction

   initial begin
      o_errors = 0;
      o_checks = 0;
   end

   // inputs and outputs are both stable at the falling edge
   always @(negedge radio_clk) begin : model
      int a;
      int b;
      int k;
      int rel;
      if (!i_arst_n) begin
         for (int ch = 0; ch < NUM_TX_CHANNELS; ch++) begin
            m_ctrl[ch]  = '0;
            m_off_i[ch] = 0;
            m_off_q[ch] = 0;
         end
         m_inc    = 0;
         m_phase  = 0;
         m_tone_i = 0;
         m_tone_q = 0;
         exp_stb  = '0;
      end else begin
         for (int ch = 0; ch < NUM_TX_CHANNELS; ch++) begin
            // --------------------
            // compare last edge
            if (i_dut_tx_stb[ch] !== exp_stb[ch]) begin
               o_errors++;
               $display("ERR %0t o_tx_stb[%0d] got %b exp %b",
                        $time, ch, i_dut_tx_stb[ch], exp_stb[ch]);
            end
            if (exp_stb[ch]) begin
               o_checks++;
               if (i_dut_tx[ch] !== {16'(exp_i[ch]), 16'(exp_q[ch])}) begin
                  o_errors++;
                  $display("ERR %0t o_tx[%0d] got (%0d,%0d) exp (%0d,%0d)", $time, ch,
                           i_dut_tx[ch].i, i_dut_tx[ch].q, exp_i[ch], exp_q[ch]);
               end
            end
            // --------------------
            // predict next edge
            a = m_ctrl[ch][0] ? m_tone_i : i_tx_host[ch].i;
            b = m_ctrl[ch][0] ? m_tone_q : i_tx_host[ch].q;
            if (m_ctrl[ch][1]) begin
               k = a;   // swap
               a = b;
               b = k;
            end
            if (m_ctrl[ch][2]) b = clip(-b);
            exp_i[ch] = clip(a + m_off_i[ch]);
            exp_q[ch] = clip(b + m_off_q[ch]);
         end
         exp_stb = i_tx_stb;
         // tone lookup uses the phase before this edge advances it
         k        = m_phase >> (PHASE_W - 4);
         m_tone_q = SINE_TABLE[k];
         m_tone_i = SINE_TABLE[(k + 4) % 16];   // cos leads by a quarter turn
         m_phase  = (m_phase + m_inc) % (2 ** PHASE_W);
         rel = int'(i_set_addr) - int'(SR_BASE);
         if (i_set_stb && rel >= 0 && rel < TONE_REL) begin
            if (rel % 2 == 0) begin
               m_ctrl[rel / 2] = i_set_data[2:0];
            end else begin
               m_off_i[rel / 2] = $signed(i_set_data[2*SAMPLE_W-1:SAMPLE_W]);
               m_off_q[rel / 2] = $signed(i_set_data[SAMPLE_W-1:0]);
            end
         end else if (i_set_stb && rel == TONE_REL) begin
            m_inc = i_set_data[PHASE_W-1:0];
         end
      end
   end

endmodule

/* tests/radio_core_tb.sv */
// testbench top: clock, reset, stimulus table with LFSR host samples, watchdog, summary
`timescale 1ns/100ps

module radio_core_tb;
   import radio_pkg::*;

   localparam logic [SET_ADDR_W-1:0] SR_BASE = 8'd160;
   localparam int RESET_CYCLES = 5;
   localparam int NUM_ROWS     = 14;
   localparam int MARGIN       = 50;   // reset, drain and slack

   typedef struct packed {
      logic                       set_stb;   // write on the first cycle of the row
      logic [SET_ADDR_W-1:0]      set_addr;
      logic [SET_DATA_W-1:0]      set_data;
      logic [NUM_TX_CHANNELS-1:0] tx_stb;
      logic                       min_i0;    // channel 0 host I forced to -32768
      logic [7:0]                 hold;      // cycles
   } stim_row_t;

   logic                       radio_clk;
   logic                       arst_n;
   logic                       set_stb;
   logic [SET_ADDR_W-1:0]      set_addr;
   settings_word_u             set_data;
   iq_sample_t                 tx_host [NUM_TX_CHANNELS];
   logic [NUM_TX_CHANNELS-1:0] tx_stb;
   iq_sample_t                 tx [NUM_TX_CHANNELS];
   logic [NUM_TX_CHANNELS-1:0] tx_stb_out;

   stim_row_t   stim [NUM_ROWS];
   iq_sample_t  host_next [NUM_TX_CHANNELS];
   logic [31:0] lfsr = 32'h10b392c4;
   logic [31:0] rnd;
   int unsigned chk_errors;
   int unsigned chk_count;
   int unsigned tb_errors = 0;
   int unsigned max_hold = 0;
   logic        table_ready = 1'b0;

   radio_core #(.SR_BASE(SR_BASE)) u_dut (
      .radio_clk (radio_clk), .i_arst_n (arst_n),
      .i_set_stb (set_stb), .i_set_addr (set_addr), .i_set_data (set_data),
      .i_tx_host (tx_host), .i_tx_stb (tx_stb), .o_tx (tx), .o_tx_stb (tx_stb_out)
   );

   radio_core_checker #(.SR_BASE(SR_BASE)) u_chk (
      .radio_clk (radio_clk), .i_arst_n (arst_n),
      .i_set_stb (set_stb), .i_set_addr (set_addr), .i_set_data (set_data),
      .i_tx_host (tx_host), .i_tx_stb (tx_stb), .i_dut_tx (tx), .i_dut_tx_stb (tx_stb_out),
      .o_errors (chk_errors), .o_checks (chk_count)
   );

   function automatic stim_row_t make_row(input logic stb, input logic [7:0] addr,
         input logic [31:0] data, input logic [1:0] strobes, input logic min_i0,
         input logic [7:0] hold);
      return '{stb, addr, data, strobes, min_i0, hold};
   endfunction

   // fibonacci lfsr, taps 32 22 2 1, one step per bit
   task automatic take_bits(input int n, output logic [31:0] v);
      logic fb;
      v = '0;
      for (int b = 0; b < n; b++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = {v[30:0], fb};
      end
   endtask

   initial begin
      radio_clk = 1'b0;
      forever #10 radio_clk = ~radio_clk;
   end

   initial begin
      wait (table_ready);
      repeat (RESET_CYCLES + NUM_ROWS * max_hold + MARGIN) @(posedge radio_clk);
      $display("watchdog: stimulus table did not complete in time");
      $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      arst_n   = 1'b0;
      set_stb  = 1'b0;
      set_addr = '0;
      set_data = '0;
      tx_stb   = '0;
      for (int ch = 0; ch < NUM_TX_CHANNELS; ch++) tx_host[ch] = '0;
      // --------------------
      // stimulus table
      stim[0]  = make_row(1'b0, SR_BASE,         32'h0,         2'b11, 1'b0, 8);  // pass through
      stim[1]  = make_row(1'b0, SR_BASE,         32'h0,         2'b01, 1'b0, 4);
      stim[2]  = make_row(1'b1, SR_BASE,         32'h6,         2'b11, 1'b0, 6);  // swap, negate
      stim[3]  = make_row(1'b0, SR_BASE,         32'h0,         2'b11, 1'b1, 3);
      stim[4]  = make_row(1'b1, SR_BASE + 8'd1,  32'h4e20_b1e0, 2'b11, 1'b0, 8);  // +-20000
      stim[5]  = make_row(1'b1, SR_BASE + 8'd3,  32'hb1e0_4e20, 2'b11, 1'b0, 8);
      stim[6]  = make_row(1'b1, SR_BASE + 8'd3,  32'h0,         2'b11, 1'b0, 2);
      stim[7]  = make_row(1'b1, SR_BASE + 8'd2,  32'h1,         2'b11, 1'b0, 6);  // tone, inc 0
      stim[8]  = make_row(1'b1, SR_BASE + 8'd4,  32'h1000,      2'b11, 1'b0, 20);
      stim[9]  = make_row(1'b1, SR_BASE - 8'd1,  32'hffff_ffff, 2'b11, 1'b0, 4);  // off the map
      stim[10] = make_row(1'b1, SR_BASE + 8'd5,  32'hffff_ffff, 2'b11, 1'b0, 4);
      stim[11] = make_row(1'b1, 8'h00,           32'hffff_ffff, 2'b11, 1'b0, 4);
      stim[12] = make_row(1'b1, SR_BASE,         32'h1,         2'b11, 1'b0, 6);  // tone clipped
      stim[13] = make_row(1'b1, SR_BASE + 8'd4,  32'h0,         2'b10, 1'b0, 4);
      foreach (stim[r]) if (stim[r].hold > max_hold) max_hold = stim[r].hold;
      table_ready = 1'b1;

      repeat (RESET_CYCLES) @(posedge radio_clk);
      arst_n <= 1'b1;
      for (int r = 0; r < NUM_ROWS; r++) begin
         for (int c = 0; c < stim[r].hold; c++) begin
            @(posedge radio_clk);
            for (int ch = 0; ch < NUM_TX_CHANNELS; ch++) begin
               take_bits(2 * SAMPLE_W, rnd);
               host_next[ch] = rnd;
            end
            if (stim[r].min_i0) host_next[0].i = SAMPLE_MIN;
            set_stb  <= stim[r].set_stb && (c == 0);
            set_addr <= stim[r].set_addr;
            set_data <= stim[r].set_data;
            tx_stb   <= stim[r].tx_stb;
            tx_host  <= host_next;
         end
      end
      @(posedge radio_clk);
      set_stb <= 1'b0;
      tx_stb  <= '0;
      repeat (3) @(posedge radio_clk);

      if (chk_count == 0) begin
         tb_errors++;
         $display("no output sample was compared");
      end
      $display("errors: checker %0d, properties %0d, testbench %0d (%0d samples compared)",
               chk_errors, u_dut.u_props.fails, tb_errors, chk_count);
      if (chk_errors + u_dut.u_props.fails + tb_errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

/* verilog.f */
hdl/radio_pkg.sv
hdl/settings_regs.sv
hdl/tone_source.sv
hdl/tx_frontend.sv
hdl/radio_core.sv
tests/radio_core_properties.sv
tests/radio_core_checker.sv
tests/radio_core_tb.sv

/* Bender.yml */
package:
  name: radio_core

sources:
  - hdl/radio_pkg.sv
  - hdl/settings_regs.sv
  - hdl/tone_source.sv
  - hdl/tx_frontend.sv
  - hdl/radio_core.sv
  - target: test
    files:
      - tests/radio_core_properties.sv
      - tests/radio_core_checker.sv
      - tests/radio_core_tb.sv
